// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := udp_arb_mux_tb
FILELIST  := compile.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// ==== compile.f ====
rtl/udp_mux_pkg.sv
rtl/udp_rr_arbiter.sv
rtl/udp_hdr_select.sv
rtl/udp_payload_path.sv
rtl/udp_arb_mux.sv
dv/tb_clk_gen.sv
dv/udp_arb_mux_asserts.sv
dv/udp_arb_mux_tb.sv

// ==== dv/tb_clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== dv/udp_arb_mux_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// udp mux output protocol checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_arb_mux_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   m_payload_valid,
    input logic                   m_payload_ready,
    input udp_mux_pkg::payload_t  m_payload_data,
    input logic                   m_payload_last,
    input udp_mux_pkg::src_mask_t s_payload_ready,
    input udp_mux_pkg::src_mask_t s_hdr_ready,
    input logic                   m_hdr_valid,
    input logic                   m_hdr_ready,
    input udp_mux_pkg::udp_port_t m_udp_source_port
);

    // stalled beat must not move
    payload_stable: assert property (@(posedge clk) disable iff (rst)
        m_payload_valid && !m_payload_ready |=>
            m_payload_valid && $stable(m_payload_data) && $stable(m_payload_last))
        else $error("payload changed while stalled");

    // payload ready for one source only and never beside header ready
    ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(s_payload_ready) && !(|s_payload_ready && |s_hdr_ready))
        else $error("payload ready not exclusive to one source");

    hdr_held: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_udp_source_port))
        else $error("header dropped before acceptance");

endmodule

bind udp_arb_mux udp_arb_mux_asserts u_asserts (
    .clk               (clk),
    .rst               (rst),
    .m_payload_valid   (m_payload_valid),
    .m_payload_ready   (m_payload_ready),
    .m_payload_data    (m_payload_data),
    .m_payload_last    (m_payload_last),
    .s_payload_ready   (s_payload_ready),
    .s_hdr_ready       (s_hdr_ready),
    .m_hdr_valid       (m_hdr_valid),
    .m_hdr_ready       (m_hdr_ready),
    .m_udp_source_port (m_udp_source_port)
);

// ==== dv/udp_arb_mux_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// udp mux directed testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_arb_mux_tb;
    import udp_mux_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int FRAMES_PER_TEST = 8;
    localparam int MAX_LEN         = 16;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * FRAMES_PER_TEST * (MAX_LEN + 10) * 4;
    localparam logic [31:0] SEED   = 32'h832d_9b88;

    logic      clk;
    logic      rst;
    src_mask_t s_hdr_valid;
    src_mask_t s_hdr_ready;
    ip_addr_t  s_ip_source_ip    [SRC_COUNT];
    ip_addr_t  s_ip_dest_ip      [SRC_COUNT];
    udp_port_t s_udp_source_port [SRC_COUNT];
    udp_port_t s_udp_dest_port   [SRC_COUNT];
    udp_len_t  s_udp_length      [SRC_COUNT];
    payload_t  s_payload_data    [SRC_COUNT];
    src_mask_t s_payload_valid;
    src_mask_t s_payload_ready;
    src_mask_t s_payload_last;
    src_mask_t s_payload_user;
    logic      m_hdr_valid;
    logic      m_hdr_ready;
    ip_addr_t  m_ip_source_ip;
    ip_addr_t  m_ip_dest_ip;
    udp_port_t m_udp_source_port;
    udp_port_t m_udp_dest_port;
    udp_len_t  m_udp_length;
    payload_t  m_payload_data;
    logic      m_payload_valid;
    logic      m_payload_ready;
    logic      m_payload_last;
    logic      m_payload_user;

    // frame table with header fields that follow from frame id and source
    int       f_src  [64];
    int       f_len  [64];
    payload_t f_data [64][MAX_LEN];
    logic     f_user [64][MAX_LEN];
    int       next_fid;

    logic [111:0] hdr_q[$];
    logic [9:0]   beat_q[$];
    int           order_q[$];

    logic [31:0] data_lcg;
    logic [31:0] stall_lcg;
    logic        stall_en;
    int          errors;
    int          checks;
    int          tests_done;
    int          cycles;

    tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    udp_arb_mux uut (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_done++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic make_frame(input int src, input int len, output int fid);
        fid = next_fid;
        next_fid++;
        f_src[fid] = src;
        f_len[fid] = len;
        for (int i = 0; i < len; i++) begin
            data_lcg = lcg_step(data_lcg);
            f_data[fid][i] = data_lcg[23:16];
            f_user[fid][i] = data_lcg[27];
        end
    endtask

    // source driver samples ready at the falling edge before the transfer edge
    task automatic send_frame(input int fid);
        int   src;
        logic seen;
        src = f_src[fid];
        @(negedge clk);
        s_hdr_valid[src]       = 1'b1;
        s_ip_source_ip[src]    = 32'h0a00_0000 + 32'(src);
        s_ip_dest_ip[src]      = 32'hc0a8_0000 + 32'(fid);
        s_udp_source_port[src] = 16'h1000 + 16'(fid);
        s_udp_dest_port[src]   = 16'h2000 + 16'(src);
        s_udp_length[src]      = 16'(8 + f_len[fid]);
        seen = 1'b0;
        while (!seen) begin
            seen = s_hdr_ready[src];
            @(negedge clk);
        end
        s_hdr_valid[src] = 1'b0;
        for (int i = 0; i < f_len[fid]; i++) begin
            s_payload_valid[src] = 1'b1;
            s_payload_data[src]  = f_data[fid][i];
            s_payload_last[src]  = (i == f_len[fid] - 1);
            s_payload_user[src]  = f_user[fid][i];
            seen = 1'b0;
            while (!seen) begin
                seen = s_payload_ready[src];
                @(negedge clk);
            end
        end
        s_payload_valid[src] = 1'b0;
        s_payload_last[src]  = 1'b0;
    endtask

    // pops n frames from the monitor queues, in output order
    task automatic verify_frames(input int first, input int n);
        int           total;
        int           fid;
        logic [111:0] h;
        logic [9:0]   b;
        total = 0;
        for (int k = first; k < first + n; k++) begin
            total += f_len[k];
        end
        while (hdr_q.size() < n || beat_q.size() < total) begin
            @(negedge clk);
        end
        order_q.delete();
        for (int k = 0; k < n; k++) begin
            h = hdr_q.pop_front();
            fid = int'(h[47:32]) - 32'h1000;
            if (fid < first || fid >= first + n) begin
                $display("output header at %0t belongs to no frame of this test", $time);
                errors++;
                return;
            end
            order_q.push_back(fid);
            check_value("m_ip_source_ip", h[111:80], 32'h0a00_0000 + 32'(f_src[fid]));
            check_value("m_ip_dest_ip", h[79:48], 32'hc0a8_0000 + 32'(fid));
            check_value("m_udp_dest_port", 32'(h[31:16]), 32'h2000 + 32'(f_src[fid]));
            check_value("m_udp_length", 32'(h[15:0]), 32'(8 + f_len[fid]));
            for (int i = 0; i < f_len[fid]; i++) begin
                b = beat_q.pop_front();
                check_value("m_payload_data", 32'(b[7:0]), 32'(f_data[fid][i]));
                check_value("m_payload_last", 32'(b[8]), 32'(i == f_len[fid] - 1));
                check_value("m_payload_user", 32'(b[9]), 32'(f_user[fid][i]));
            end
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_value("m_hdr_valid", 32'(m_hdr_valid), 0);
        check_value("m_payload_valid", 32'(m_payload_valid), 0);
        check_value("s_hdr_ready", 32'(s_hdr_ready), 0);
        check_value("s_payload_ready", 32'(s_payload_ready), 0);
        finish_test("reset", e);
    endtask

    task automatic test_round_robin();
        int e;
        int f[6];
        e = errors;
        for (int s = 0; s < SRC_COUNT; s++) begin
            make_frame(s, 3 + s, f[s]);
        end
        fork
            send_frame(f[0]);
            send_frame(f[1]);
            send_frame(f[2]);
            send_frame(f[3]);
        join
        verify_frames(f[0], 4);
        for (int k = 0; k < 4; k++) begin
            check_value("frame order", 32'(order_q[k]), 32'(f[k]));
        end
        make_frame(1, 5, f[4]);
        make_frame(3, 2, f[5]);
        fork
            send_frame(f[4]);
            send_frame(f[5]);
        join
        verify_frames(f[4], 2);
        check_value("frame order", 32'(order_q[0]), 32'(f[4]));
        check_value("frame order", 32'(order_q[1]), 32'(f[5]));
        finish_test("round robin", e);
    endtask

    task automatic test_single();
        int e;
        int fid;
        e = errors;
        make_frame(2, 9, fid);
        send_frame(fid);
        verify_frames(fid, 1);
        finish_test("single frame", e);
    endtask

    // two frames per source with random lengths
    task automatic run_all_sources(input string name);
        int e;
        int f[8];
        e = errors;
        for (int k = 0; k < 8; k++) begin
            data_lcg = lcg_step(data_lcg);
            make_frame(k % SRC_COUNT, 1 + int'(data_lcg[31:28]), f[k]);
        end
        fork
            begin
                send_frame(f[0]);
                send_frame(f[4]);
            end
            begin
                send_frame(f[1]);
                send_frame(f[5]);
            end
            begin
                send_frame(f[2]);
                send_frame(f[6]);
            end
            begin
                send_frame(f[3]);
                send_frame(f[7]);
            end
        join
        verify_frames(f[0], 8);
        finish_test(name, e);
    endtask

    task automatic test_hdr_backpressure();
        int e;
        int f0;
        int f1;
        e = errors;
        // source 0 follows source 2 in round-robin order
        make_frame(0, 4, f0);
        make_frame(1, 6, f1);
        m_hdr_ready = 1'b0;
        fork
            send_frame(f0);
            send_frame(f1);
            begin
                while (!m_hdr_valid) begin
                    @(negedge clk);
                end
                repeat (30) begin
                    @(negedge clk);
                    check_value("m_hdr_valid", 32'(m_hdr_valid), 1);
                    check_value("m_ip_source_ip", m_ip_source_ip,
                                32'h0a00_0000 + 32'(f_src[f0]));
                    check_value("m_ip_dest_ip", m_ip_dest_ip, 32'hc0a8_0000 + 32'(f0));
                    check_value("m_udp_source_port", 32'(m_udp_source_port),
                                32'h1000 + 32'(f0));
                    check_value("m_udp_dest_port", 32'(m_udp_dest_port),
                                32'h2000 + 32'(f_src[f0]));
                    check_value("m_udp_length", 32'(m_udp_length), 32'(8 + f_len[f0]));
                    check_value("s_hdr_ready", 32'(s_hdr_ready), 0);
                end
                m_hdr_ready = 1'b1;
            end
        join
        verify_frames(f0, 2);
        check_value("frame order", 32'(order_q[0]), 32'(f0));
        check_value("frame order", 32'(order_q[1]), 32'(f1));
        finish_test("header back-pressure", e);
    endtask

    // output monitor
    always @(posedge clk) begin
        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) begin
                hdr_q.push_back({m_ip_source_ip, m_ip_dest_ip, m_udp_source_port,
                                 m_udp_dest_port, m_udp_length});
            end
            if (m_payload_valid && m_payload_ready) begin
                beat_q.push_back({m_payload_user, m_payload_last, m_payload_data});
            end
        end
    end

    always @(negedge clk) begin
        stall_lcg = lcg_step(stall_lcg);
        m_payload_ready = stall_en ? stall_lcg[29] : 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        s_hdr_valid     = '0;
        s_payload_valid = '0;
        s_payload_last  = '0;
        s_payload_user  = '0;
        for (int s = 0; s < SRC_COUNT; s++) begin
            s_ip_source_ip[s]    = '0;
            s_ip_dest_ip[s]      = '0;
            s_udp_source_port[s] = '0;
            s_udp_dest_port[s]   = '0;
            s_udp_length[s]      = '0;
            s_payload_data[s]    = '0;
        end
        m_hdr_ready     = 1'b1;
        m_payload_ready = 1'b1;
        stall_en   = 1'b0;
        data_lcg   = SEED;
        stall_lcg  = SEED;
        next_fid   = 0;
        errors     = 0;
        checks     = 0;
        tests_done = 0;
        cycles     = 0;
        @(negedge clk);
        while (rst !== 1'b0) begin
            @(negedge clk);
        end
        test_reset();
        // round robin runs first so that source 0 still leads
        test_round_robin();
        test_single();
        run_all_sources("no interleaving");
        stall_en = 1'b1;
        run_all_sources("payload back-pressure");
        stall_en = 1'b0;
        test_hdr_backpressure();
        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== rtl/udp_arb_mux.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-source udp frame multiplexer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_arb_mux (
    input  logic                   clk,
    input  logic                   rst,

    // source side
    input  udp_mux_pkg::src_mask_t s_hdr_valid,
    output udp_mux_pkg::src_mask_t s_hdr_ready,
    input  udp_mux_pkg::ip_addr_t  s_ip_source_ip    [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::ip_addr_t  s_ip_dest_ip      [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::udp_port_t s_udp_source_port [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::udp_port_t s_udp_dest_port   [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::udp_len_t  s_udp_length      [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::payload_t  s_payload_data    [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::src_mask_t s_payload_valid,
    output udp_mux_pkg::src_mask_t s_payload_ready,
    input  udp_mux_pkg::src_mask_t s_payload_last,
    input  udp_mux_pkg::src_mask_t s_payload_user,

    // output frame channel
    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output udp_mux_pkg::ip_addr_t  m_ip_source_ip,
    output udp_mux_pkg::ip_addr_t  m_ip_dest_ip,
    output udp_mux_pkg::udp_port_t m_udp_source_port,
    output udp_mux_pkg::udp_port_t m_udp_dest_port,
    output udp_mux_pkg::udp_len_t  m_udp_length,
    output udp_mux_pkg::payload_t  m_payload_data,
    output logic                   m_payload_valid,
    input  logic                   m_payload_ready,
    output logic                   m_payload_last,
    output logic                   m_payload_user
);
    import udp_mux_pkg::*;

    logic     grant_valid;
    src_idx_t grant_idx;
    logic     frame_done;
    logic     frame_active;

    // a pending header is the request for the channel
    udp_rr_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (s_hdr_valid),
        .frame_done  (frame_done),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    udp_hdr_select u_hdr_select (
        .clk               (clk),
        .rst               (rst),
        .grant_valid       (grant_valid),
        .grant_idx         (grant_idx),
        .frame_done        (frame_done),
        .frame_active      (frame_active),
        .s_hdr_ready       (s_hdr_ready),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .s_udp_source_port (s_udp_source_port),
        .s_udp_dest_port   (s_udp_dest_port),
        .s_udp_length      (s_udp_length),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_udp_source_port (m_udp_source_port),
        .m_udp_dest_port   (m_udp_dest_port),
        .m_udp_length      (m_udp_length)
    );

    udp_payload_path u_payload_path (
        .clk             (clk),
        .rst             (rst),
        .grant_valid     (grant_valid),
        .grant_idx       (grant_idx),
        .frame_active    (frame_active),
        .s_payload_data  (s_payload_data),
        .s_payload_valid (s_payload_valid),
        .s_payload_last  (s_payload_last),
        .s_payload_user  (s_payload_user),
        .s_payload_ready (s_payload_ready),
        .frame_done      (frame_done),
        .m_payload_data  (m_payload_data),
        .m_payload_valid (m_payload_valid),
        .m_payload_last  (m_payload_last),
        .m_payload_user  (m_payload_user),
        .m_payload_ready (m_payload_ready)
    );

endmodule

// ==== rtl/udp_hdr_select.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// udp header select and hold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_hdr_select (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   grant_valid,
    input  udp_mux_pkg::src_idx_t  grant_idx,
    input  logic                   frame_done,
    output logic                   frame_active,
    output udp_mux_pkg::src_mask_t s_hdr_ready,
    input  udp_mux_pkg::ip_addr_t  s_ip_source_ip    [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::ip_addr_t  s_ip_dest_ip      [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::udp_port_t s_udp_source_port [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::udp_port_t s_udp_dest_port   [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::udp_len_t  s_udp_length      [udp_mux_pkg::SRC_COUNT],
    output logic                   m_hdr_valid,
    input  logic                   m_hdr_ready,
    output udp_mux_pkg::ip_addr_t  m_ip_source_ip,
    output udp_mux_pkg::ip_addr_t  m_ip_dest_ip,
    output udp_mux_pkg::udp_port_t m_udp_source_port,
    output udp_mux_pkg::udp_port_t m_udp_dest_port,
    output udp_mux_pkg::udp_len_t  m_udp_length
);
    import udp_mux_pkg::*;

    frame_state_t state;
    logic         hdr_valid_reg;
    logic         start;

    // new frame only once the previous header has left
    assign start = (state == FRAME_IDLE) && grant_valid && !hdr_valid_reg;

    assign s_hdr_ready  = start ? (src_mask_t'(1) << grant_idx) : '0;
    assign frame_active = (state == FRAME_ACTIVE);
    assign m_hdr_valid  = hdr_valid_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= FRAME_IDLE;
            hdr_valid_reg <= 1'b0;
        end else begin
            case (state)
                FRAME_IDLE: begin
                    if (start) begin
                        state <= FRAME_ACTIVE;
                    end
                end
                FRAME_ACTIVE: begin
                    if (frame_done) begin
                        state <= FRAME_IDLE;
                    end
                end
                default: state <= FRAME_IDLE;
            endcase

            if (start) begin
                hdr_valid_reg <= 1'b1;
            end else if (m_hdr_ready) begin
                hdr_valid_reg <= 1'b0;
            end
        end
    end

    // header holding register, loaded once per frame
    always_ff @(posedge clk) begin
        if (start) begin
            m_ip_source_ip    <= s_ip_source_ip[grant_idx];
            m_ip_dest_ip      <= s_ip_dest_ip[grant_idx];
            m_udp_source_port <= s_udp_source_port[grant_idx];
            m_udp_dest_port   <= s_udp_dest_port[grant_idx];
            m_udp_length      <= s_udp_length[grant_idx];
        end
    end

endmodule

// ==== rtl/udp_mux_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// udp mux shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package udp_mux_pkg;

    // source count and derived index width
    localparam int SRC_COUNT     = 4;
    localparam int SRC_IDX_WIDTH = 2;

    // payload beat width
    localparam int DATA_WIDTH    = 8;

    typedef logic [SRC_IDX_WIDTH-1:0] src_idx_t;
    typedef logic [SRC_COUNT-1:0]     src_mask_t;

    // reduced udp header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    typedef logic [DATA_WIDTH-1:0] payload_t;

    // open or closed frame on the output channel
    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_t;

endpackage

// ==== rtl/udp_payload_path.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// payload select and skid buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_payload_path (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   grant_valid,
    input  udp_mux_pkg::src_idx_t  grant_idx,
    input  logic                   frame_active,
    input  udp_mux_pkg::payload_t  s_payload_data [udp_mux_pkg::SRC_COUNT],
    input  udp_mux_pkg::src_mask_t s_payload_valid,
    input  udp_mux_pkg::src_mask_t s_payload_last,
    input  udp_mux_pkg::src_mask_t s_payload_user,
    output udp_mux_pkg::src_mask_t s_payload_ready,
    output logic                   frame_done,
    output udp_mux_pkg::payload_t  m_payload_data,
    output logic                   m_payload_valid,
    output logic                   m_payload_last,
    output logic                   m_payload_user,
    input  logic                   m_payload_ready
);
    import udp_mux_pkg::*;

    logic     ready_int_reg;
    logic     take;
    logic     accept;
    logic     out_valid_next;
    logic     temp_valid;
    logic     temp_valid_next;
    payload_t temp_data;
    logic     temp_last;
    logic     temp_user;
    logic     store_out;
    logic     store_temp;
    logic     temp_to_out;

    // payload only flows once the frame header has been taken
    assign take   = grant_valid && frame_active && ready_int_reg;
    assign accept = take && s_payload_valid[grant_idx];

    assign s_payload_ready = take ? (src_mask_t'(1) << grant_idx) : '0;
    assign frame_done      = accept && s_payload_last[grant_idx];

    always_comb begin
        out_valid_next  = m_payload_valid;
        temp_valid_next = temp_valid;
        store_out       = 1'b0;
        store_temp      = 1'b0;
        temp_to_out     = 1'b0;
        if (ready_int_reg) begin
            if (m_payload_ready || !m_payload_valid) begin
                out_valid_next = accept;
                store_out      = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = accept;
                store_temp      = 1'b1;
            end
        end else if (m_payload_ready) begin
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_valid <= 1'b0;
            temp_valid      <= 1'b0;
            ready_int_reg   <= 1'b0;
        end else begin
            m_payload_valid <= out_valid_next;
            temp_valid      <= temp_valid_next;
            // stays high unless the skid entry could fill next cycle
            ready_int_reg   <= m_payload_ready || (!temp_valid && (!m_payload_valid || !accept));
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            m_payload_data <= s_payload_data[grant_idx];
            m_payload_last <= s_payload_last[grant_idx];
            m_payload_user <= s_payload_user[grant_idx];
        end else if (temp_to_out) begin
            m_payload_data <= temp_data;
            m_payload_last <= temp_last;
            m_payload_user <= temp_user;
        end
        if (store_temp) begin
            temp_data <= s_payload_data[grant_idx];
            temp_last <= s_payload_last[grant_idx];
            temp_user <= s_payload_user[grant_idx];
        end
    end

endmodule

// ==== rtl/udp_rr_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round-robin frame arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module udp_rr_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  udp_mux_pkg::src_mask_t request,
    input  logic                   frame_done,
    output logic                   grant_valid,
    output udp_mux_pkg::src_idx_t  grant_idx
);
    import udp_mux_pkg::*;

    src_mask_t grant_reg;
    src_mask_t masked_req;
    src_idx_t  last_idx;
    src_idx_t  cand;
    src_idx_t  next_idx;
    logic      found;

    // a source that already owns the channel does not compete
    assign masked_req  = request & ~grant_reg;
    assign grant_valid = |grant_reg;

    // first requester after the last winner, wrapping around
    always_comb begin
        next_idx = last_idx;
        found    = 1'b0;
        cand     = last_idx;
        for (int i = 1; i <= SRC_COUNT; i++) begin
            cand = last_idx + src_idx_t'(i);
            if (!found && masked_req[cand]) begin
                next_idx = cand;
                found    = 1'b1;
            end
        end
    end

    // one-hot grant to index
    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < SRC_COUNT; i++) begin
            if (grant_reg[i]) begin
                grant_idx = src_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_reg <= '0;
            // source 0 wins first after reset
            last_idx  <= src_idx_t'(SRC_COUNT - 1);
        end else if (grant_valid) begin
            // hold until the last beat of the frame is taken
            if (frame_done) begin
                grant_reg <= '0;
            end
        end else if (found) begin
            grant_reg <= src_mask_t'(1) << next_idx;
            last_idx  <= next_idx;
        end
    end

endmodule
